// ==== common/mcPkg.sv ====
package mcPkg;

	// widths of the raw instruction fields seen by the control unit
	localparam int opcodeWidth = 6;
	localparam int functWidth = 6;
	localparam int fmtWidth = 5;

	// widths of the multi-bit datapath selects
	localparam int pcSourceWidth = 3;
	localparam int aluSrcBWidth = 3;
	localparam int aluOpWidth = 2;
	localparam int aluSrcAWidth = 2;

	// interrupt lines, exception cause and state encodings
	localparam int irqWidth = 8;
	localparam int excCodeWidth = 5;
	localparam int stateWidth = 5;

	typedef enum logic [opcodeWidth-1:0] {
		OP_RFMT = 6'd0, OP_J = 6'd2, OP_JAL = 6'd3, OP_BEQ = 6'd4, OP_BNE = 6'd5,
		OP_ADDI = 6'd8, OP_ADDIU = 6'd9, OP_SLTI = 6'd10, OP_SLTIU = 6'd11,
		OP_ANDI = 6'd12, OP_ORI = 6'd13, OP_XORI = 6'd14, OP_LUI = 6'd15,
		OP_COP0 = 6'd16, OP_LW = 6'd35, OP_SW = 6'd43
	} opcodeT;

	typedef enum logic [functWidth-1:0] {
		FN_SLL = 6'd0, FN_SRL = 6'd2, FN_SRA = 6'd3, FN_JR = 6'd8, FN_SYSCALL = 6'd12,
		FN_MULT = 6'd24, FN_MULTU = 6'd25, FN_DIV = 6'd26, FN_DIVU = 6'd27,
		FN_ADD = 6'd32, FN_SUB = 6'd34
	} functT;

	// eret shares its function code with mult, it is only meaningful under the COP0 opcode
	localparam functT eretFunct = FN_MULT;

	// rs field of a COP0 instruction
	typedef enum logic [fmtWidth-1:0] {
		FMT_MF = 5'd0,
		FMT_MT = 5'd4,
		FMT_ERET = 5'd16
	} cop0FmtT;

	typedef enum logic [stateWidth-1:0] {
		FETCH = 5'd0, DECODE, MEMADDR, MEMREAD, MEMWB, MEMWRITE,
		RFMT, RFMT2, SHIFT, IMMLOGIC, IMMARITH, IMMWB,
		BEQ, BNE, JUMP, JAL, JR, MTC0, MFC0, ERET, EXC
	} stateT;

	// cause values as they appear in the COP0 cause register
	typedef enum logic [excCodeWidth-1:0] {
		INT = 5'd0,
		SYS = 5'd8,
		RI = 5'd10,
		OV = 5'd12
	} excCodeT;

	// one datapath control word, driven whole from the current state
	typedef struct packed {
		logic pcWrite;
		logic pcWriteBne;
		logic pcWriteBeq;
		logic iOrD;
		logic memRead;
		logic memWrite;
		logic irWrite;
		logic memToReg;
		logic [pcSourceWidth-1:0] pcSource;
		logic [aluOpWidth-1:0] aluOp;
		logic [aluSrcBWidth-1:0] aluSrcB;
		logic [aluSrcAWidth-1:0] aluSrcA;
		logic regWrite;
		logic regDst;
	} ctrlWordT;

endpackage

// ==== common/decodeIf.sv ====
interface decodeIf;

	// state to enter after DECODE, already EXC when the instruction traps
	mcPkg::stateT dispatch;
	// second step of a memory access, MEMREAD for loads and MEMWRITE for stores
	mcPkg::stateT memTarget;
	// the instruction itself is illegal, privileged or a syscall
	logic trap;
	mcPkg::excCodeT trapCause;
	// branches and jumps, the places where an interrupt is taken at DECODE
	logic delaySlot;

	modport decoder
	(
		output dispatch, memTarget, trap, trapCause, delaySlot
	);

	modport sequencer
	(
		input dispatch, memTarget, trap, trapCause, delaySlot
	);

endinterface

// ==== logic/instrDecoder.sv ====
module instrDecoder
(
	input mcPkg::opcodeT opcode,
	input mcPkg::functT funct,
	input mcPkg::cop0FmtT fmt,
	input logic userMode,
	decodeIf.decoder dec
);

	mcPkg::stateT execState;
	mcPkg::stateT memState;
	logic illegal;
	logic sysCall;
	logic isBranch;
	logic trap;

	// classify the instruction held in the IR into its first execute state
	always_comb
	begin
		execState = mcPkg::EXC;
		memState = mcPkg::MEMREAD;
		illegal = 1'b0;
		sysCall = 1'b0;
		isBranch = 1'b0;
		case (opcode)
			mcPkg::OP_RFMT:
			begin
				case (funct)
					mcPkg::FN_SLL, mcPkg::FN_SRL, mcPkg::FN_SRA:
						execState = mcPkg::SHIFT;
					mcPkg::FN_JR:
					begin
						execState = mcPkg::JR;
						isBranch = 1'b1;
					end
					// every syscall traps, there are no serviced codes left
					mcPkg::FN_SYSCALL:
						sysCall = 1'b1;
					// remaining function codes are decoded by the ALU control
					default:
						execState = mcPkg::RFMT;
				endcase
			end
			mcPkg::OP_J:
			begin
				execState = mcPkg::JUMP;
				isBranch = 1'b1;
			end
			mcPkg::OP_JAL:
			begin
				execState = mcPkg::JAL;
				isBranch = 1'b1;
			end
			mcPkg::OP_BEQ:
			begin
				execState = mcPkg::BEQ;
				isBranch = 1'b1;
			end
			mcPkg::OP_BNE:
			begin
				execState = mcPkg::BNE;
				isBranch = 1'b1;
			end
			mcPkg::OP_ADDI, mcPkg::OP_ADDIU, mcPkg::OP_SLTI, mcPkg::OP_SLTIU, mcPkg::OP_LUI:
				execState = mcPkg::IMMARITH;
			// logical immediates need a zero-extended operand
			mcPkg::OP_ANDI, mcPkg::OP_ORI, mcPkg::OP_XORI:
				execState = mcPkg::IMMLOGIC;
			mcPkg::OP_LW:
				execState = mcPkg::MEMADDR;
			mcPkg::OP_SW:
			begin
				execState = mcPkg::MEMADDR;
				memState = mcPkg::MEMWRITE;
			end
			mcPkg::OP_COP0:
			begin
				// any COP0 access from user mode is privileged
				if (userMode)
					illegal = 1'b1;
				else if (fmt == mcPkg::FMT_MF)
					execState = mcPkg::MFC0;
				else if (fmt == mcPkg::FMT_MT)
					execState = mcPkg::MTC0;
				else if (fmt == mcPkg::FMT_ERET && funct == mcPkg::eretFunct)
					execState = mcPkg::ERET;
				else
					illegal = 1'b1;
			end
			default:
				illegal = 1'b1;
		endcase
	end

	assign trap = illegal || sysCall;

	assign dec.trap = trap;
	assign dec.trapCause = sysCall ? mcPkg::SYS : mcPkg::RI;
	assign dec.dispatch = trap ? mcPkg::EXC : execState;
	assign dec.memTarget = memState;
	assign dec.delaySlot = isBranch;

endmodule

// ==== logic/excMonitor.sv ====
module excMonitor
(
	input mcPkg::opcodeT opcode,
	input mcPkg::functT funct,
	input logic aluOverflow,
	input logic excLevel,
	input logic [mcPkg::irqWidth-1:0] pendingIrq,
	output logic intTake,
	output logic ovfTrap
);

	logic signedAdd;
	logic irqPending;

	// only the trapping forms of add and subtract report overflow
	// addu, subu and addiu share the ALU but never raise OV
	assign signedAdd = (opcode == mcPkg::OP_RFMT
		&& (funct == mcPkg::FN_ADD || funct == mcPkg::FN_SUB))
		|| opcode == mcPkg::OP_ADDI;

	// any unmasked line counts, masking per line happens in COP0 status
	assign irqPending = |pendingIrq;

	// while the handler runs at exception level nothing else is taken
	assign intTake = irqPending && !excLevel;
	assign ovfTrap = signedAdd && aluOverflow && !excLevel;

endmodule

// ==== sequencer/ctrlTable.sv ====
module ctrlTable
(
	input mcPkg::stateT state,
	output mcPkg::ctrlWordT ctrl
);

	// pcSource 0 ALU, 1 ALUOut, 2 jump target, 3 register, 4 handler, 5 EPC
	// aluSrcB 1 constant four, 2 sign-extended, 3 shifted offset, 4 zero-extended
	// aluOp 0 add, 1 subtract for compare, 2 funct field, 3 opcode field
	always_comb
	begin
		ctrl = '0;
		case (state)
			mcPkg::FETCH:
			begin
				// PC+4 is written back while the instruction is loaded
				ctrl.memRead = 1'b1;
				ctrl.irWrite = 1'b1;
				ctrl.pcWrite = 1'b1;
				ctrl.aluSrcB = 3'd1;
			end
			// branch target is computed early, in case it is needed
			mcPkg::DECODE:
				ctrl.aluSrcB = 3'd3;
			mcPkg::MEMADDR:
			begin
				ctrl.aluSrcA = 2'd1;
				ctrl.aluSrcB = 3'd2;
			end
			mcPkg::MEMREAD:
			begin
				ctrl.memRead = 1'b1;
				ctrl.iOrD = 1'b1;
			end
			mcPkg::MEMWRITE:
			begin
				ctrl.memWrite = 1'b1;
				ctrl.iOrD = 1'b1;
			end
			mcPkg::MEMWB:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
			end
			mcPkg::RFMT:
			begin
				ctrl.aluOp = 2'd2;
				ctrl.aluSrcA = 2'd1;
			end
			// shifts take the shift amount on source A
			mcPkg::SHIFT:
			begin
				ctrl.aluOp = 2'd2;
				ctrl.aluSrcA = 2'd2;
			end
			mcPkg::RFMT2:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1;
			end
			mcPkg::IMMLOGIC:
			begin
				ctrl.aluOp = 2'd3;
				ctrl.aluSrcA = 2'd1;
				ctrl.aluSrcB = 3'd4;
			end
			mcPkg::IMMARITH:
			begin
				ctrl.aluOp = 2'd3;
				ctrl.aluSrcA = 2'd1;
				ctrl.aluSrcB = 3'd2;
			end
			mcPkg::IMMWB, mcPkg::MFC0:
				ctrl.regWrite = 1'b1;
			mcPkg::BEQ, mcPkg::BNE:
			begin
				// the ALU compares the registers, its zero flag qualifies the write
				ctrl.pcWriteBeq = state == mcPkg::BEQ;
				ctrl.pcWriteBne = state == mcPkg::BNE;
				ctrl.pcSource = 3'd1;
				ctrl.aluOp = 2'd1;
				ctrl.aluSrcA = 2'd1;
			end
			mcPkg::JUMP, mcPkg::JAL:
			begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSource = 3'd2;
				// jal links into the return address register
				ctrl.regWrite = state == mcPkg::JAL;
			end
			mcPkg::JR:
			begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSource = 3'd3;
			end
			mcPkg::ERET:
			begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSource = 3'd5;
			end
			mcPkg::EXC:
			begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSource = 3'd4;
			end
			default:
				ctrl = '0;
		endcase
	end

endmodule

// ==== sequencer/mcSequencer.sv ====
module mcSequencer
(
	input logic iCLK,
	input logic iRST,
	input mcPkg::functT funct,
	input mcPkg::opcodeT opcode,
	decodeIf.sequencer dec,
	input logic intTake,
	input logic ovfTrap,
	output mcPkg::stateT state,
	output mcPkg::ctrlWordT ctrl,
	output mcPkg::excCodeT excCode,
	output logic cop0RegWrite,
	output logic eret,
	output logic excOccurred
);

	mcPkg::stateT nextState;
	mcPkg::excCodeT nextCause;
	mcPkg::excCodeT causeReg;
	logic mulDiv;
	logic ovfTake;

	// mult and div write HI/LO inside the ALU, so they skip the register write-back
	assign mulDiv = funct inside {mcPkg::FN_MULT, mcPkg::FN_MULTU,
		mcPkg::FN_DIV, mcPkg::FN_DIVU};

	// the monitor flags overflow for add, sub and addi alike
	// here it only counts in the write-back state of its own format
	always_comb
	begin
		ovfTake = 1'b0;
		if (state == mcPkg::RFMT2)
			ovfTake = ovfTrap && opcode == mcPkg::OP_RFMT;
		else if (state == mcPkg::IMMWB)
			ovfTake = ovfTrap && opcode == mcPkg::OP_ADDI;
	end

	always_comb
	begin
		nextState = mcPkg::FETCH;
		// overflow wins over a pending interrupt in the same cycle
		nextCause = ovfTake ? mcPkg::OV : mcPkg::INT;
		case (state)
			mcPkg::FETCH:
				nextState = mcPkg::DECODE;
			mcPkg::DECODE:
			begin
				nextCause = dec.trap ? dec.trapCause : mcPkg::INT;
				// interrupts are taken before a branch or jump changes the PC
				if (dec.delaySlot && intTake)
					nextState = mcPkg::EXC;
				else
					nextState = dec.dispatch;
			end
			mcPkg::MEMADDR:
				nextState = dec.memTarget;
			mcPkg::MEMREAD:
				nextState = mcPkg::MEMWB;
			mcPkg::MEMWB, mcPkg::MEMWRITE:
				nextState = intTake ? mcPkg::EXC : mcPkg::FETCH;
			mcPkg::RFMT:
				nextState = mulDiv ? mcPkg::FETCH : mcPkg::RFMT2;
			mcPkg::SHIFT:
				nextState = mcPkg::RFMT2;
			mcPkg::IMMLOGIC, mcPkg::IMMARITH:
				nextState = mcPkg::IMMWB;
			mcPkg::RFMT2, mcPkg::IMMWB:
				nextState = (ovfTake || intTake) ? mcPkg::EXC : mcPkg::FETCH;
			// branches, jumps, COP0 moves, eret and EXC all end here
			default:
				nextState = mcPkg::FETCH;
		endcase
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			state <= mcPkg::FETCH;
		else
			state <= nextState;
	end

	// cause is captured only on the edge that enters EXC and is held afterwards
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			causeReg <= mcPkg::INT;
		else if (nextState == mcPkg::EXC)
			causeReg <= nextCause;
	end

	ctrlTable ctrlTable_inst
	(
		.state(state),
		.ctrl(ctrl)
	);

	assign excCode = causeReg;
	assign cop0RegWrite = state == mcPkg::MTC0;
	assign eret = state == mcPkg::ERET;
	assign excOccurred = state == mcPkg::EXC;

endmodule

// ==== logic/multiCycleControl.sv ====
module multiCycleControl
(
	input logic iCLK,
	input logic iRST,
	input logic [mcPkg::opcodeWidth-1:0] opcode,
	input logic [mcPkg::functWidth-1:0] funct,
	input logic [mcPkg::fmtWidth-1:0] fmt,
	input logic userMode,
	input logic aluOverflow,
	input logic excLevel,
	input logic [mcPkg::irqWidth-1:0] pendingIrq,
	output logic [mcPkg::stateWidth-1:0] state,
	output logic pcWrite,
	output logic pcWriteBne,
	output logic pcWriteBeq,
	output logic iOrD,
	output logic memRead,
	output logic memWrite,
	output logic irWrite,
	output logic memToReg,
	output logic [mcPkg::pcSourceWidth-1:0] pcSource,
	output logic [mcPkg::aluOpWidth-1:0] aluOp,
	output logic [mcPkg::aluSrcBWidth-1:0] aluSrcB,
	output logic [mcPkg::aluSrcAWidth-1:0] aluSrcA,
	output logic regWrite,
	output logic regDst,
	output logic cop0RegWrite,
	output logic eret,
	output logic excOccurred,
	output logic [mcPkg::excCodeWidth-1:0] excCode,
	output logic branchDelay
);

	decodeIf decBus ();

	mcPkg::stateT seqState;
	mcPkg::ctrlWordT ctrl;
	mcPkg::excCodeT seqCause;
	logic intTake;
	logic ovfTrap;

	// raw instruction fields are cast so unknown codes still reach the decoder
	instrDecoder instrDecoder_inst
	(
		.opcode(mcPkg::opcodeT'(opcode)),
		.funct(mcPkg::functT'(funct)),
		.fmt(mcPkg::cop0FmtT'(fmt)),
		.userMode(userMode),
		.dec(decBus.decoder)
	);

	excMonitor excMonitor_inst
	(
		.opcode(mcPkg::opcodeT'(opcode)),
		.funct(mcPkg::functT'(funct)),
		.aluOverflow(aluOverflow),
		.excLevel(excLevel),
		.pendingIrq(pendingIrq),
		.intTake(intTake),
		.ovfTrap(ovfTrap)
	);

	mcSequencer mcSequencer_inst
	(
		.iCLK(iCLK),
		.iRST(iRST),
		.funct(mcPkg::functT'(funct)),
		.opcode(mcPkg::opcodeT'(opcode)),
		.dec(decBus.sequencer),
		.intTake(intTake),
		.ovfTrap(ovfTrap),
		.state(seqState),
		.ctrl(ctrl),
		.excCode(seqCause),
		.cop0RegWrite(cop0RegWrite),
		.eret(eret),
		.excOccurred(excOccurred)
	);

	assign state = seqState;
	assign excCode = seqCause;
	// COP0 records this to point EPC at the branch instead of its delay slot
	assign branchDelay = decBus.delaySlot;

	assign pcWrite = ctrl.pcWrite;
	assign pcWriteBne = ctrl.pcWriteBne;
	assign pcWriteBeq = ctrl.pcWriteBeq;
	assign iOrD = ctrl.iOrD;
	assign memRead = ctrl.memRead;
	assign memWrite = ctrl.memWrite;
	assign irWrite = ctrl.irWrite;
	assign memToReg = ctrl.memToReg;
	assign pcSource = ctrl.pcSource;
	assign aluOp = ctrl.aluOp;
	assign aluSrcB = ctrl.aluSrcB;
	assign aluSrcA = ctrl.aluSrcA;
	assign regWrite = ctrl.regWrite;
	assign regDst = ctrl.regDst;

endmodule

// ==== bench/multiCycleControl_assertions.sv ====
module multiCycleControl_assertions
(
	input logic iCLK,
	input logic iRST,
	input logic [mcPkg::stateWidth-1:0] state,
	input logic memRead,
	input logic memWrite,
	input logic excOccurred
);

	timeunit 1ns;
	timeprecision 100ps;

	// read by the testbench when it totals the errors
	int failCount = 0;

	// EXC is a single cycle that always hands over to FETCH
	excReturn: assert property (@(posedge iCLK) disable iff (iRST)
		excOccurred |=> state == mcPkg::FETCH)
	else
	begin
		failCount++;
		$error("exception state was not followed by FETCH");
	end

	// the memory port is either read or written, never both
	memExclusive: assert property (@(posedge iCLK) !(memRead && memWrite))
	else
	begin
		failCount++;
		$error("memRead and memWrite are high together");
	end

	resetFetch: assert property (@(posedge iCLK) $fell(iRST) |-> state == mcPkg::FETCH)
	else
	begin
		failCount++;
		$error("state is not FETCH after reset is released");
	end

endmodule

bind multiCycleControl multiCycleControl_assertions assertions_inst (.*);

// ==== bench/multiCycleControlTb.sv ====
module multiCycleControlTb;

	timeunit 1ns;
	timeprecision 100ps;

	logic iCLK;
	logic iRST;
	logic [mcPkg::opcodeWidth-1:0] opcode;
	logic [mcPkg::functWidth-1:0] funct;
	logic [mcPkg::fmtWidth-1:0] fmt;
	logic userMode;
	logic aluOverflow;
	logic excLevel;
	logic [mcPkg::irqWidth-1:0] pendingIrq;
	logic [mcPkg::stateWidth-1:0] state;
	logic pcWrite;
	logic pcWriteBne;
	logic pcWriteBeq;
	logic iOrD;
	logic memRead;
	logic memWrite;
	logic irWrite;
	logic memToReg;
	logic [mcPkg::pcSourceWidth-1:0] pcSource;
	logic [mcPkg::aluOpWidth-1:0] aluOp;
	logic [mcPkg::aluSrcBWidth-1:0] aluSrcB;
	logic [mcPkg::aluSrcAWidth-1:0] aluSrcA;
	logic regWrite;
	logic regDst;
	logic cop0RegWrite;
	logic eret;
	logic excOccurred;
	logic [mcPkg::excCodeWidth-1:0] excCode;
	logic branchDelay;

	int errorCount;
	int testCount;
	int failedTests;
	int totalErrors;
	logic [31:0] lfsrState;
	// expected walk of the current instruction, DECODE first
	mcPkg::stateT expPath [0:4];
	int expLen;
	// cause of the most recent expected exception
	logic [mcPkg::excCodeWidth-1:0] lastCode;
	logic codeKnown;

	multiCycleControl multiCycleControl_inst (.*);

	always #20 iCLK = ~iCLK;

	function automatic logic [31:0] lfsrBits(input int count);
		logic [31:0] value;
		int i;
		value = '0;
		for (i = 0; i < count; i++)
		begin
			// Galois step with polynomial x^32 + x^22 + x^2 + x + 1
			if (lfsrState[0])
				lfsrState = (lfsrState >> 1) ^ 32'h80200003;
			else
				lfsrState = lfsrState >> 1;
			value = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	task automatic checkEq(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			errorCount++;
			$display("Mismatch at time %0t: %s expected %0h actual %0h",
				$time, name, expected, actual);
		end
	endtask

	// outputs settle before the inputs move, so sampling here is race free
	task automatic nextCycle();
		@(posedge iCLK);
		#2;
	endtask

	task automatic checkState(input string name, input mcPkg::stateT s);
		logic [8:0] strobes;
		int src;
		int srcB;
		int srcA;
		int aluMode;
		// groups are {pcWrite, pcWriteBne, pcWriteBeq} {iOrD, memRead, memWrite}
		// and {irWrite, regWrite, regDst}, -1 leaves a select unchecked
		strobes = '0;
		src = -1;
		srcB = -1;
		srcA = -1;
		case (s)
			mcPkg::FETCH:
			begin
				strobes = 9'b100_010_100;
				srcB = 1;
			end
			mcPkg::DECODE:
				srcB = 3;
			mcPkg::MEMADDR:
			begin
				srcA = 1;
				srcB = 2;
			end
			mcPkg::MEMREAD:
				strobes = 9'b000_110_000;
			mcPkg::MEMWRITE:
				strobes = 9'b000_101_000;
			mcPkg::MEMWB, mcPkg::MFC0, mcPkg::IMMWB:
				strobes = 9'b000_000_010;
			mcPkg::RFMT2:
				strobes = 9'b000_000_011;
			mcPkg::BEQ:
			begin
				strobes = 9'b001_000_000;
				src = 1;
			end
			mcPkg::BNE:
			begin
				strobes = 9'b010_000_000;
				src = 1;
			end
			mcPkg::JUMP, mcPkg::JAL:
			begin
				strobes = (s == mcPkg::JAL) ? 9'b100_000_010 : 9'b100_000_000;
				src = 2;
			end
			mcPkg::JR, mcPkg::ERET, mcPkg::EXC:
			begin
				strobes = 9'b100_000_000;
				src = (s == mcPkg::JR) ? 3 : (s == mcPkg::ERET) ? 5 : 4;
			end
			default:
				strobes = '0;
		endcase
		// the ALU adds for PC and address arithmetic and subtracts for branch compares
		// R-format follows the funct field and immediates follow the opcode field
		case (s)
			mcPkg::BEQ, mcPkg::BNE:
				aluMode = 1;
			mcPkg::RFMT, mcPkg::SHIFT:
				aluMode = 2;
			mcPkg::IMMLOGIC, mcPkg::IMMARITH:
				aluMode = 3;
			default:
				aluMode = 0;
		endcase
		checkEq({name, " state"}, state, s);
		checkEq({name, " strobes"}, {pcWrite, pcWriteBne, pcWriteBeq, iOrD, memRead,
			memWrite, irWrite, regWrite, regDst}, strobes);
		checkEq({name, " excOccurred"}, excOccurred, s == mcPkg::EXC);
		checkEq({name, " cop0RegWrite"}, cop0RegWrite, s == mcPkg::MTC0);
		checkEq({name, " eret"}, eret, s == mcPkg::ERET);
		// only a load writes memory data back to the register file
		checkEq({name, " memToReg"}, memToReg, s == mcPkg::MEMWB);
		checkEq({name, " aluOp"}, aluOp, aluMode);
		if (src >= 0)
			checkEq({name, " pcSource"}, pcSource, src);
		if (srcB >= 0)
			checkEq({name, " aluSrcB"}, aluSrcB, srcB);
		if (srcA >= 0)
			checkEq({name, " aluSrcA"}, aluSrcA, srcA);
	endtask

	// state sequence after FETCH for each instruction class of the timing table
	task automatic buildPath(input logic [5:0] op, input logic [5:0] fn, input logic [4:0] fm);
		expLen = 2;
		expPath[0] = mcPkg::DECODE;
		case (op)
			mcPkg::OP_J:
				expPath[1] = mcPkg::JUMP;
			mcPkg::OP_JAL:
				expPath[1] = mcPkg::JAL;
			mcPkg::OP_BEQ:
				expPath[1] = mcPkg::BEQ;
			mcPkg::OP_BNE:
				expPath[1] = mcPkg::BNE;
			mcPkg::OP_COP0:
			begin
				if (fm == mcPkg::FMT_MT)
					expPath[1] = mcPkg::MTC0;
				else if (fm == mcPkg::FMT_MF)
					expPath[1] = mcPkg::MFC0;
				else
					expPath[1] = mcPkg::ERET;
			end
			mcPkg::OP_LW:
			begin
				expLen = 4;
				expPath[1] = mcPkg::MEMADDR;
				expPath[2] = mcPkg::MEMREAD;
				expPath[3] = mcPkg::MEMWB;
			end
			mcPkg::OP_SW:
			begin
				expLen = 3;
				expPath[1] = mcPkg::MEMADDR;
				expPath[2] = mcPkg::MEMWRITE;
			end
			mcPkg::OP_ANDI, mcPkg::OP_ORI, mcPkg::OP_XORI:
			begin
				expLen = 3;
				expPath[1] = mcPkg::IMMLOGIC;
				expPath[2] = mcPkg::IMMWB;
			end
			mcPkg::OP_RFMT:
			begin
				if (fn == mcPkg::FN_JR)
					expPath[1] = mcPkg::JR;
				else if (fn inside {mcPkg::FN_MULT, mcPkg::FN_MULTU, mcPkg::FN_DIV,
					mcPkg::FN_DIVU})
					expPath[1] = mcPkg::RFMT;
				else
				begin
					expLen = 3;
					if (fn inside {mcPkg::FN_SLL, mcPkg::FN_SRL, mcPkg::FN_SRA})
						expPath[1] = mcPkg::SHIFT;
					else
						expPath[1] = mcPkg::RFMT;
					expPath[2] = mcPkg::RFMT2;
				end
			end
			default:
			begin
				expLen = 3;
				expPath[1] = mcPkg::IMMARITH;
				expPath[2] = mcPkg::IMMWB;
			end
		endcase
	endtask

	task automatic waitFetch(output int cycles);
		cycles = 0;
		do
		begin
			nextCycle();
			cycles++;
		end
		while (state != mcPkg::FETCH && cycles < 20);
		if (state != mcPkg::FETCH)
		begin
			errorCount++;
			$display("Timeout at time %0t: the state did not return to FETCH in 20 cycles",
				$time);
		end
	endtask

	// starts in a FETCH cycle, excAt is the slot where EXC replaces the walk
	task automatic runInstr(input string name, input logic [5:0] op, input logic [5:0] fn,
		input logic [4:0] fm, input int excAt, input int code);
		int i;
		int backCycles;
		logic isJump;
		buildPath(op, fn, fm);
		if (excAt >= 0)
		begin
			expPath[excAt] = mcPkg::EXC;
			expLen = excAt + 1;
		end
		isJump = op inside {mcPkg::OP_J, mcPkg::OP_JAL, mcPkg::OP_BEQ, mcPkg::OP_BNE}
			|| (op == mcPkg::OP_RFMT && fn == mcPkg::FN_JR);
		checkState(name, mcPkg::FETCH);
		opcode = op;
		funct = fn;
		fmt = fm;
		for (i = 0; i < expLen; i++)
		begin
			nextCycle();
			checkState(name, expPath[i]);
			if (expPath[i] == mcPkg::DECODE)
				checkEq({name, " branchDelay"}, branchDelay, isJump);
			if (expPath[i] == mcPkg::EXC)
				checkEq({name, " excCode"}, excCode, code);
		end
		// every path, EXC included, hands over to FETCH on the next edge
		waitFetch(backCycles);
		checkEq({name, " cycles to FETCH"}, backCycles, 1);
		if (excAt >= 0)
		begin
			lastCode = code;
			codeKnown = 1'b1;
		end
		if (codeKnown)
			checkEq({name, " held excCode"}, excCode, lastCode);
	endtask

	task automatic runNormal(input int idx);
		case (idx)
			0: runInstr("j", mcPkg::OP_J, 0, 0, -1, 0);
			1: runInstr("jal", mcPkg::OP_JAL, 0, 0, -1, 0);
			2: runInstr("jr", mcPkg::OP_RFMT, mcPkg::FN_JR, 0, -1, 0);
			3: runInstr("beq", mcPkg::OP_BEQ, 0, 0, -1, 0);
			4: runInstr("bne", mcPkg::OP_BNE, 0, 0, -1, 0);
			5: runInstr("mtc0", mcPkg::OP_COP0, 0, mcPkg::FMT_MT, -1, 0);
			6: runInstr("mfc0", mcPkg::OP_COP0, 0, mcPkg::FMT_MF, -1, 0);
			7: runInstr("eret", mcPkg::OP_COP0, mcPkg::FN_MULT, mcPkg::FMT_ERET, -1, 0);
			8: runInstr("mult", mcPkg::OP_RFMT, mcPkg::FN_MULT, 0, -1, 0);
			9: runInstr("multu", mcPkg::OP_RFMT, mcPkg::FN_MULTU, 0, -1, 0);
			10: runInstr("div", mcPkg::OP_RFMT, mcPkg::FN_DIV, 0, -1, 0);
			11: runInstr("divu", mcPkg::OP_RFMT, mcPkg::FN_DIVU, 0, -1, 0);
			12: runInstr("add", mcPkg::OP_RFMT, mcPkg::FN_ADD, 0, -1, 0);
			13: runInstr("sub", mcPkg::OP_RFMT, mcPkg::FN_SUB, 0, -1, 0);
			14: runInstr("sll", mcPkg::OP_RFMT, mcPkg::FN_SLL, 0, -1, 0);
			15: runInstr("srl", mcPkg::OP_RFMT, mcPkg::FN_SRL, 0, -1, 0);
			16: runInstr("sra", mcPkg::OP_RFMT, mcPkg::FN_SRA, 0, -1, 0);
			17: runInstr("addi", mcPkg::OP_ADDI, 0, 0, -1, 0);
			18: runInstr("addiu", mcPkg::OP_ADDIU, 0, 0, -1, 0);
			19: runInstr("slti", mcPkg::OP_SLTI, 0, 0, -1, 0);
			20: runInstr("sltiu", mcPkg::OP_SLTIU, 0, 0, -1, 0);
			21: runInstr("lui", mcPkg::OP_LUI, 0, 0, -1, 0);
			22: runInstr("andi", mcPkg::OP_ANDI, 0, 0, -1, 0);
			23: runInstr("ori", mcPkg::OP_ORI, 0, 0, -1, 0);
			24: runInstr("xori", mcPkg::OP_XORI, 0, 0, -1, 0);
			25: runInstr("sw", mcPkg::OP_SW, 0, 0, -1, 0);
			default: runInstr("lw", mcPkg::OP_LW, 0, 0, -1, 0);
		endcase
	endtask

	task automatic reportTest(input string name, input int errBefore);
		testCount++;
		if (errorCount != errBefore)
			failedTests++;
		$display("test %s finished with %0d errors", name, errorCount - errBefore);
	endtask

	task automatic testReset();
		int errBefore;
		errBefore = errorCount;
		checkState("reset", mcPkg::FETCH);
		reportTest("reset", errBefore);
	endtask

	task automatic testNormal();
		int errBefore;
		int start;
		int k;
		errBefore = errorCount;
		// a random rotation of the instruction list sets the order
		start = lfsrBits(5) % 27;
		for (k = 0; k < 27; k++)
			runNormal((start + k) % 27);
		reportTest("normal walks", errBefore);
	endtask

	task automatic testTraps();
		int errBefore;
		errBefore = errorCount;
		runInstr("unknown opcode", 6'd63, 0, 0, 1, mcPkg::RI);
		runInstr("syscall", mcPkg::OP_RFMT, mcPkg::FN_SYSCALL, 0, 1, mcPkg::SYS);
		userMode = 1'b1;
		runInstr("user mtc0", mcPkg::OP_COP0, 0, mcPkg::FMT_MT, 1, mcPkg::RI);
		userMode = 1'b0;
		runInstr("bad eret", mcPkg::OP_COP0, 0, mcPkg::FMT_ERET, 1, mcPkg::RI);
		reportTest("traps", errBefore);
	endtask

	task automatic testOverflow();
		int errBefore;
		errBefore = errorCount;
		aluOverflow = 1'b1;
		runInstr("add ovf", mcPkg::OP_RFMT, mcPkg::FN_ADD, 0, 3, mcPkg::OV);
		runInstr("sub ovf", mcPkg::OP_RFMT, mcPkg::FN_SUB, 0, 3, mcPkg::OV);
		runInstr("addi ovf", mcPkg::OP_ADDI, 0, 0, 3, mcPkg::OV);
		// at exception level the overflow is ignored
		excLevel = 1'b1;
		runInstr("add masked", mcPkg::OP_RFMT, mcPkg::FN_ADD, 0, -1, 0);
		runInstr("sub masked", mcPkg::OP_RFMT, mcPkg::FN_SUB, 0, -1, 0);
		runInstr("addi masked", mcPkg::OP_ADDI, 0, 0, -1, 0);
		aluOverflow = 1'b0;
		excLevel = 1'b0;
		reportTest("overflow", errBefore);
	endtask

	task automatic testInterrupt();
		int errBefore;
		logic [31:0] irqBits;
		errBefore = errorCount;
		irqBits = lfsrBits(mcPkg::irqWidth);
		pendingIrq = irqBits[mcPkg::irqWidth-1:0];
		if (pendingIrq == 0)
			pendingIrq = 1;
		runInstr("beq irq", mcPkg::OP_BEQ, 0, 0, 1, mcPkg::INT);
		runInstr("lw irq", mcPkg::OP_LW, 0, 0, 4, mcPkg::INT);
		excLevel = 1'b1;
		runInstr("beq irq masked", mcPkg::OP_BEQ, 0, 0, -1, 0);
		runInstr("lw irq masked", mcPkg::OP_LW, 0, 0, -1, 0);
		pendingIrq = '0;
		excLevel = 1'b0;
		reportTest("interrupts", errBefore);
	endtask

	// a syscall latches a nonzero cause, then cop0 moves and eret leave it alone
	task automatic testKernelCop0();
		int errBefore;
		errBefore = errorCount;
		runInstr("kernel syscall", mcPkg::OP_RFMT, mcPkg::FN_SYSCALL, 0, 1, mcPkg::SYS);
		runNormal(5);
		runNormal(7);
		runNormal(6);
		reportTest("kernel cop0", errBefore);
	endtask

	initial
	begin
		iCLK = 1'b0;
		iRST = 1'b1;
		opcode = '0;
		funct = '0;
		fmt = '0;
		userMode = 1'b0;
		aluOverflow = 1'b0;
		excLevel = 1'b0;
		pendingIrq = '0;
		errorCount = 0;
		testCount = 0;
		failedTests = 0;
		lfsrState = 32'h870f;
		lastCode = '0;
		codeKnown = 1'b0;
		repeat (5) @(posedge iCLK);
		#2;
		iRST = 1'b0;
		testReset();
		testNormal();
		testTraps();
		testOverflow();
		testInterrupt();
		testKernelCop0();
		totalErrors = errorCount + multiCycleControl_inst.assertions_inst.failCount;
		$display("tests %0d, failed tests %0d, errors %0d", testCount, failedTests, totalErrors);
		if (totalErrors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== compile.f ====
common/mcPkg.sv
common/decodeIf.sv
logic/instrDecoder.sv
logic/excMonitor.sv
sequencer/ctrlTable.sv
sequencer/mcSequencer.sv
logic/multiCycleControl.sv
bench/multiCycleControl_assertions.sv
bench/multiCycleControlTb.sv
